/* common/axi_bridge_pkg.sv */
`default_nettype none

package axi_bridge_pkg;

	parameter int data_w = 32;

	typedef logic [31:0] addr_t;        // byte address
	typedef logic [data_w-1:0] data_t;
	typedef logic [data_w/8-1:0] strb_t;
	typedef logic [2:0] size_t;         // passed straight from the cache request type
	typedef logic [3:0] len_t;          // beats minus one
	typedef logic [3:0] id_t;

	// read ids, used to steer R beats back
	parameter id_t id_inst = 4'd0;
	parameter id_t id_data = 4'd1;

	parameter len_t len_single = 4'd0;
	parameter len_t len_line = 4'd15;   // 16 word line on the read side

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr  = 2'b01
	} burst_e;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,
		rd_data
	} rd_state_e;

	typedef enum logic [1:0] {
		wr_idle,
		wr_addr,
		wr_data,
		wr_resp
	} wr_state_e;

endpackage

`default_nettype wire

/* axi_bridge/read_channel.sv */
`timescale 1ns/1ns
`default_nettype none

module read_channel (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         icache_rd_req,
	input  wire axi_bridge_pkg::addr_t  icache_rd_addr,
	input  wire axi_bridge_pkg::size_t  icache_rd_size,
	output logic                        icache_rd_rdy,
	output logic                        icache_ret_valid,
	output logic                        icache_ret_last,
	output axi_bridge_pkg::data_t       icache_ret_data,
	input  wire                         dcache_rd_req,
	input  wire axi_bridge_pkg::addr_t  dcache_rd_addr,
	input  wire axi_bridge_pkg::size_t  dcache_rd_size,
	input  wire                         dcache_rd_uncached,
	output logic                        dcache_rd_rdy,
	output logic                        dcache_ret_valid,
	output logic                        dcache_ret_last,
	output axi_bridge_pkg::data_t       dcache_ret_data,
	output axi_bridge_pkg::id_t         arid,
	output axi_bridge_pkg::addr_t       araddr,
	output axi_bridge_pkg::len_t        arlen,
	output axi_bridge_pkg::size_t       arsize,
	output axi_bridge_pkg::burst_e      arburst,
	output logic                        arvalid,
	input  wire                         arready,
	input  wire axi_bridge_pkg::id_t    rid,
	input  wire axi_bridge_pkg::data_t  rdata,
	input  wire                         rlast,
	input  wire                         rvalid
);

	import axi_bridge_pkg::*;

	rd_state_e state;
	rd_state_e state_nxt;
	logic icache_acc;
	logic dcache_acc;

	assign icache_rd_rdy = (state == rd_idle);
	assign dcache_rd_rdy = (state == rd_idle) && !icache_rd_req;  // icache wins a tie
	assign icache_acc = icache_rd_req && icache_rd_rdy;
	assign dcache_acc = dcache_rd_req && dcache_rd_rdy;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= rd_idle;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			rd_idle:
				if (icache_acc || dcache_acc)
					state_nxt = rd_addr;
			rd_addr:
				if (arready)        // arvalid is high throughout rd_addr
					state_nxt = rd_data;
			rd_data:
				if (rvalid && rlast)
					state_nxt = rd_idle;
			default:
				state_nxt = rd_idle;
		endcase
	end

	// AR fields held steady from acceptance until the burst ends
	always_ff @(posedge clk)
	begin
		if (icache_acc)
		begin
			araddr  <= icache_rd_addr;
			arsize  <= icache_rd_size;
			arid    <= id_inst;
			arlen   <= len_line;
			arburst <= burst_incr;
		end
		else if (dcache_acc)
		begin
			araddr  <= dcache_rd_addr;
			arsize  <= dcache_rd_size;
			arid    <= id_data;
			// uncached data is a single fixed beat
			arlen   <= dcache_rd_uncached ? len_single : len_line;
			arburst <= dcache_rd_uncached ? burst_fixed : burst_incr;
		end
	end

	assign arvalid = (state == rd_addr);

	// steer R beats by id
	assign icache_ret_valid = (state == rd_data) && rvalid && (rid == id_inst);
	assign dcache_ret_valid = (state == rd_data) && rvalid && (rid == id_data);
	assign icache_ret_last = rlast && (rid == id_inst);
	assign dcache_ret_last = rlast && (rid == id_data);
	assign icache_ret_data = rdata;
	assign dcache_ret_data = rdata;

endmodule

`default_nettype wire

/* axi_bridge/write_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module write_buffer #(
	parameter int line_beats = 16
) (
	input  wire                                         clk,
	input  wire                                         rst,
	input  wire                                         load,
	input  wire                                         beat,
	input  wire                                         uncached,
	input  wire [line_beats*axi_bridge_pkg::data_w-1:0] line,
	input  wire axi_bridge_pkg::data_t                  word,
	output axi_bridge_pkg::data_t                       wdata,
	output logic                                        wlast
);

	import axi_bridge_pkg::*;

	localparam int line_w = line_beats * data_w;
	localparam int cnt_w = (line_beats > 1) ? $clog2(line_beats) : 1;

	logic [line_w-1:0] line_q;
	data_t word_q;
	logic [cnt_w-1:0] cnt;  // beats already sent

	// next W beat always sits in the low word
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			line_q <= line;
			word_q <= word;
		end
		else if (beat)
			line_q <= line_q >> data_w;
	end

	always_ff @(posedge clk)
	begin
		if (!rst || load)
			cnt <= '0;
		else if (beat)
			cnt <= cnt + 1'b1;
	end

	assign wdata = uncached ? word_q : line_q[data_w-1:0];
	assign wlast = uncached || (cnt == cnt_w'(line_beats - 1));  // single word is its own last

endmodule

`default_nettype wire

/* axi_bridge/write_channel.sv */
`timescale 1ns/1ns
`default_nettype none

module write_channel #(
	parameter int line_beats = 16
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         dcache_wr_req,
	input  wire axi_bridge_pkg::addr_t  dcache_wr_addr,
	input  wire axi_bridge_pkg::size_t  dcache_wr_size,
	input  wire axi_bridge_pkg::strb_t  dcache_wr_strb,
	input  wire                         dcache_wr_uncached,
	output logic                        dcache_wr_rdy,
	output axi_bridge_pkg::addr_t       awaddr,
	output axi_bridge_pkg::len_t        awlen,
	output axi_bridge_pkg::size_t       awsize,
	output axi_bridge_pkg::burst_e      awburst,
	output logic                        awvalid,
	input  wire                         awready,
	output logic                        wvalid,
	output axi_bridge_pkg::strb_t       wstrb,
	input  wire                         wready,
	input  wire                         wlast,
	input  wire                         bvalid,
	output logic                        load,
	output logic                        beat,
	output logic                        uncached_q
);

	import axi_bridge_pkg::*;

	wr_state_e state;
	wr_state_e state_nxt;

	assign dcache_wr_rdy = (state == wr_idle);
	assign load = dcache_wr_req && dcache_wr_rdy;   // buffer grabs line and word
	assign awvalid = (state == wr_addr);
	assign wvalid = (state == wr_data);
	assign beat = wvalid && wready;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= wr_idle;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			wr_idle:
				if (load)
					state_nxt = wr_addr;
			wr_addr:
				if (awready)
					state_nxt = wr_data;
			wr_data:
				if (beat && wlast)  // last beat accepted
					state_nxt = wr_resp;
			wr_resp:
				if (bvalid)
					state_nxt = wr_idle;
			default:
				state_nxt = wr_idle;
		endcase
	end

	// word or line select for the buffer
	always_ff @(posedge clk)
	begin
		if (!rst)
			uncached_q <= 1'b0;
		else if (load)
			uncached_q <= dcache_wr_uncached;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			awaddr  <= dcache_wr_addr;
			awsize  <= dcache_wr_size;
			wstrb   <= dcache_wr_strb;
			awlen   <= dcache_wr_uncached ? len_single : len_t'(line_beats - 1);
			awburst <= dcache_wr_uncached ? burst_fixed : burst_incr;
		end
	end

endmodule

`default_nettype wire

/* axi_bridge/axi_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_bridge #(
	parameter int line_beats = 16
) (
	input  wire                              clk,
	input  wire                              rst,
	// icache read
	input  wire                              icache_rd_req,
	input  wire axi_bridge_pkg::addr_t       icache_rd_addr,
	input  wire axi_bridge_pkg::size_t       icache_rd_size,
	output logic                             icache_rd_rdy,
	output logic                             icache_ret_valid,
	output logic                             icache_ret_last,
	output axi_bridge_pkg::data_t            icache_ret_data,
	// dcache read
	input  wire                              dcache_rd_req,
	input  wire axi_bridge_pkg::addr_t       dcache_rd_addr,
	input  wire axi_bridge_pkg::size_t       dcache_rd_size,
	input  wire                              dcache_rd_uncached,
	output logic                             dcache_rd_rdy,
	output logic                             dcache_ret_valid,
	output logic                             dcache_ret_last,
	output axi_bridge_pkg::data_t            dcache_ret_data,
	// dcache write
	input  wire                              dcache_wr_req,
	input  wire axi_bridge_pkg::addr_t       dcache_wr_addr,
	input  wire axi_bridge_pkg::size_t       dcache_wr_size,
	input  wire axi_bridge_pkg::strb_t       dcache_wr_strb,
	input  wire                              dcache_wr_uncached,
	input  wire [line_beats*axi_bridge_pkg::data_w-1:0] dcache_wr_line,
	input  wire axi_bridge_pkg::data_t       dcache_wr_word,
	output logic                             dcache_wr_rdy,
	// AXI read address / data
	output axi_bridge_pkg::id_t              arid,
	output axi_bridge_pkg::addr_t            araddr,
	output axi_bridge_pkg::len_t             arlen,
	output axi_bridge_pkg::size_t            arsize,
	output axi_bridge_pkg::burst_e           arburst,
	output logic                             arvalid,
	input  wire                              arready,
	input  wire axi_bridge_pkg::id_t         rid,
	input  wire axi_bridge_pkg::data_t       rdata,
	input  wire                              rlast,
	input  wire                              rvalid,
	// AXI write address / data / response
	output axi_bridge_pkg::addr_t            awaddr,
	output axi_bridge_pkg::len_t             awlen,
	output axi_bridge_pkg::size_t            awsize,
	output axi_bridge_pkg::burst_e           awburst,
	output logic                             awvalid,
	input  wire                              awready,
	output axi_bridge_pkg::data_t            wdata,
	output axi_bridge_pkg::strb_t            wstrb,
	output logic                             wlast,
	output logic                             wvalid,
	input  wire                              wready,
	input  wire                              bvalid
);

	logic wr_load;      // line captured this cycle
	logic wr_beat;      // W handshake
	logic wr_uncached;

	read_channel u_read_channel (
		.clk                (clk),
		.rst                (rst),
		.icache_rd_req      (icache_rd_req),
		.icache_rd_addr     (icache_rd_addr),
		.icache_rd_size     (icache_rd_size),
		.icache_rd_rdy      (icache_rd_rdy),
		.icache_ret_valid   (icache_ret_valid),
		.icache_ret_last    (icache_ret_last),
		.icache_ret_data    (icache_ret_data),
		.dcache_rd_req      (dcache_rd_req),
		.dcache_rd_addr     (dcache_rd_addr),
		.dcache_rd_size     (dcache_rd_size),
		.dcache_rd_uncached (dcache_rd_uncached),
		.dcache_rd_rdy      (dcache_rd_rdy),
		.dcache_ret_valid   (dcache_ret_valid),
		.dcache_ret_last    (dcache_ret_last),
		.dcache_ret_data    (dcache_ret_data),
		.arid               (arid),
		.araddr             (araddr),
		.arlen              (arlen),
		.arsize             (arsize),
		.arburst            (arburst),
		.arvalid            (arvalid),
		.arready            (arready),
		.rid                (rid),
		.rdata              (rdata),
		.rlast              (rlast),
		.rvalid             (rvalid)
	);

	write_channel #(
		.line_beats (line_beats)
	) u_write_channel (
		.clk                (clk),
		.rst                (rst),
		.dcache_wr_req      (dcache_wr_req),
		.dcache_wr_addr     (dcache_wr_addr),
		.dcache_wr_size     (dcache_wr_size),
		.dcache_wr_strb     (dcache_wr_strb),
		.dcache_wr_uncached (dcache_wr_uncached),
		.dcache_wr_rdy      (dcache_wr_rdy),
		.awaddr             (awaddr),
		.awlen              (awlen),
		.awsize             (awsize),
		.awburst            (awburst),
		.awvalid            (awvalid),
		.awready            (awready),
		.wvalid             (wvalid),
		.wstrb              (wstrb),
		.wready             (wready),
		.wlast              (wlast),
		.bvalid             (bvalid),
		.load               (wr_load),
		.beat               (wr_beat),
		.uncached_q         (wr_uncached)
	);

	write_buffer #(
		.line_beats (line_beats)
	) u_write_buffer (
		.clk      (clk),
		.rst      (rst),
		.load     (wr_load),
		.beat     (wr_beat),
		.uncached (wr_uncached),
		.line     (dcache_wr_line),
		.word     (dcache_wr_word),
		.wdata    (wdata),
		.wlast    (wlast)
	);

endmodule

`default_nettype wire

/* tb/tb_axi_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_slave (
	input  wire                         clk,
	input  wire                         rst,
	input  wire axi_bridge_pkg::id_t    arid,
	input  wire axi_bridge_pkg::addr_t  araddr,
	input  wire axi_bridge_pkg::len_t   arlen,
	input  wire axi_bridge_pkg::size_t  arsize,
	input  wire axi_bridge_pkg::burst_e arburst,
	input  wire                         arvalid,
	output logic                        arready,
	output axi_bridge_pkg::id_t         rid,
	output axi_bridge_pkg::data_t       rdata,
	output logic                        rlast,
	output logic                        rvalid,
	input  wire axi_bridge_pkg::addr_t  awaddr,
	input  wire axi_bridge_pkg::len_t   awlen,
	input  wire axi_bridge_pkg::size_t  awsize,
	input  wire axi_bridge_pkg::burst_e awburst,
	input  wire                         awvalid,
	output logic                        awready,
	input  wire axi_bridge_pkg::data_t  wdata,
	input  wire axi_bridge_pkg::strb_t  wstrb,
	input  wire                         wlast,
	input  wire                         wvalid,
	output logic                        wready,
	output logic                        bvalid
);

	import axi_bridge_pkg::*;

	localparam int log_depth = 1024;

	logic [31:0] dice;      // fresh random bits each cycle
	addr_t rd_base;
	len_t rd_len;
	logic rd_fixed;
	logic rd_busy;
	logic [4:0] rd_idx;     // next beat to send
	len_t last_arlen;
	size_t last_arsize;
	burst_e last_arburst;
	logic wr_busy;
	logic b_pend;           // response owed for the last W beat
	addr_t wr_addr;
	len_t wr_len;
	size_t wr_size;
	burst_e wr_burst;

	// one entry per accepted W beat
	data_t log_data [0:log_depth-1];
	strb_t log_strb [0:log_depth-1];
	logic log_last [0:log_depth-1];
	addr_t log_addr [0:log_depth-1];
	len_t log_len [0:log_depth-1];
	size_t log_size [0:log_depth-1];
	burst_e log_burst [0:log_depth-1];
	int log_cnt;

	always @(posedge clk)
	begin
		dice = $urandom;
		if (!rst)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rd_busy <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			wr_busy <= 1'b0;
			b_pend <= 1'b0;
			log_cnt <= 0;
		end
		else
		begin
			if (arvalid && arready)
			begin
				rd_base <= araddr;
				rd_len <= arlen;
				rd_fixed <= (arburst == burst_fixed);
				rid <= arid;
				last_arlen <= arlen;
				last_arsize <= arsize;
				last_arburst <= arburst;
				rd_idx <= 5'd0;
				rd_busy <= 1'b1;
				arready <= 1'b0;
			end
			else if (!rd_busy)
				arready <= dice[0];

			if (rd_busy)
			begin
				if (rvalid && rlast)
				begin
					rvalid <= 1'b0;
					rd_busy <= 1'b0;
				end
				else if (dice[1])
				begin
					rvalid <= 1'b1;
					rdata <= ((rd_base >> 2) + (rd_fixed ? 32'd0 : 32'(rd_idx))) ^ 32'h5a5a_0000;
					rlast <= (rd_idx == {1'b0, rd_len});
					rd_idx <= rd_idx + 5'd1;
				end
				else
					rvalid <= 1'b0;   // gap between beats
			end

			if (awvalid && awready)
			begin
				wr_addr <= awaddr;
				wr_len <= awlen;
				wr_size <= awsize;
				wr_burst <= awburst;
				wr_busy <= 1'b1;
				awready <= 1'b0;
			end
			else if (!wr_busy)
				awready <= dice[2];

			if (wr_busy && !b_pend)
			begin
				if (wvalid && wready)
				begin
					if (log_cnt < log_depth)
					begin
						log_data[log_cnt] <= wdata;
						log_strb[log_cnt] <= wstrb;
						log_last[log_cnt] <= wlast;
						log_addr[log_cnt] <= wr_addr;
						log_len[log_cnt] <= wr_len;
						log_size[log_cnt] <= wr_size;
						log_burst[log_cnt] <= wr_burst;
					end
					log_cnt <= log_cnt + 1;
					if (wlast)
						b_pend <= 1'b1;
					wready <= wlast ? 1'b0 : dice[3];
				end
				else
					wready <= dice[3];
			end

			if (bvalid)
			begin
				bvalid <= 1'b0;
				b_pend <= 1'b0;
				wr_busy <= 1'b0;
			end
			else if (b_pend)
				bvalid <= dice[4];
		end
	end

endmodule

`default_nettype wire

/* tb/axi_bridge_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_bridge_assert (
	input wire                         clk,
	input wire                         rst,
	input wire                         arvalid,
	input wire                         arready,
	input wire axi_bridge_pkg::addr_t  araddr,
	input wire axi_bridge_pkg::id_t    arid,
	input wire axi_bridge_pkg::len_t   arlen,
	input wire axi_bridge_pkg::burst_e arburst,
	input wire                         awvalid,
	input wire                         awready,
	input wire axi_bridge_pkg::addr_t  awaddr,
	input wire axi_bridge_pkg::len_t   awlen,
	input wire axi_bridge_pkg::burst_e awburst,
	input wire                         wvalid,
	input wire                         wready,
	input wire                         wlast,
	input wire axi_bridge_pkg::data_t  wdata,
	input wire                         icache_ret_valid,
	input wire                         dcache_ret_valid
);

	import axi_bridge_pkg::*;

	// address channels hold until taken
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid)
			&& $stable(arlen) && $stable(arburst))
		else $error("AR channel changed while waiting for arready");

	a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen)
			&& $stable(awburst))
		else $error("AW channel changed while waiting for awready");

	a_w_hold: assert property (@(posedge clk) disable iff (!rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
		else $error("W beat changed while waiting for wready");

	// wlast only counts when it rides on a W handshake
	a_w_last: assert property (@(posedge clk) disable iff (!rst)
		wvalid && wready && wlast |=> !wvalid)
		else $error("W data continued after the beat with wlast");

	// one cache per beat, and it is the one that issued the burst
	a_ret_route: assert property (@(posedge clk) disable iff (!rst)
		(icache_ret_valid || dcache_ret_valid) |->
			(icache_ret_valid != dcache_ret_valid)
			&& (arid == (icache_ret_valid ? id_inst : id_data)))
		else $error("read beat routed to a cache that did not issue the burst");

endmodule

bind axi_bridge axi_bridge_assert u_axi_bridge_assert (
	.clk(clk), .rst(rst),
	.arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid),
	.arlen(arlen), .arburst(arburst),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awlen(awlen),
	.awburst(awburst),
	.wvalid(wvalid), .wready(wready), .wlast(wlast), .wdata(wdata),
	.icache_ret_valid(icache_ret_valid), .dcache_ret_valid(dcache_ret_valid)
);

`default_nettype wire

/* tb/tb_axi_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_bridge;

	import axi_bridge_pkg::*;

	localparam int line_beats = 16;
	localparam int max_cycles = 20000;   // about 200 transactions of up to 60 cycles with margin
	localparam data_t rd_key = 32'h5a5a_0000;

	logic clk = 1'b0;
	logic rst;
	logic icache_rd_req;
	addr_t icache_rd_addr;
	size_t icache_rd_size;
	logic icache_rd_rdy;
	logic icache_ret_valid;
	logic icache_ret_last;
	data_t icache_ret_data;
	logic dcache_rd_req;
	addr_t dcache_rd_addr;
	size_t dcache_rd_size;
	logic dcache_rd_uncached;
	logic dcache_rd_rdy;
	logic dcache_ret_valid;
	logic dcache_ret_last;
	data_t dcache_ret_data;
	logic dcache_wr_req;
	addr_t dcache_wr_addr;
	size_t dcache_wr_size;
	strb_t dcache_wr_strb;
	logic dcache_wr_uncached;
	logic [line_beats*data_w-1:0] dcache_wr_line;
	data_t dcache_wr_word;
	logic dcache_wr_rdy;
	id_t arid;
	addr_t araddr;
	len_t arlen;
	size_t arsize;
	burst_e arburst;
	logic arvalid;
	logic arready;
	id_t rid;
	data_t rdata;
	logic rlast;
	logic rvalid;
	addr_t awaddr;
	len_t awlen;
	size_t awsize;
	burst_e awburst;
	logic awvalid;
	logic awready;
	data_t wdata;
	strb_t wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic bvalid;

	// returned beats in arrival order
	data_t ret_data_q[$];
	logic ret_last_q[$];
	logic ret_src_q[$];     // 0 means icache
	int lasts_seen = 0;
	int cycles = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	axi_bridge #(.line_beats(line_beats)) DUT (.*);

	tb_axi_slave u_slave (.*);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Verification failed");
			$finish;
		end
	end

	always @(negedge clk)   // ret outputs settle mid-cycle
	begin
		if (icache_ret_valid)
		begin
			ret_data_q.push_back(icache_ret_data);
			ret_last_q.push_back(icache_ret_last);
			ret_src_q.push_back(1'b0);
			if (icache_ret_last)
				lasts_seen++;
		end
		if (dcache_ret_valid)
		begin
			ret_data_q.push_back(dcache_ret_data);
			ret_last_q.push_back(dcache_ret_last);
			ret_src_q.push_back(1'b1);
			if (dcache_ret_last)
				lasts_seen++;
		end
	end

	task automatic step();
		@(posedge clk);
		#5;
	endtask

	task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		errors++;
	endtask

	// expected slave word for one beat of a burst
	function automatic data_t read_word(addr_t base, int idx);
		return ((base >> 2) + 32'(idx)) ^ rd_key;
	endfunction

	// n beats from one cache starting at queue entry first
	task automatic check_beats(int first, int n, logic src, addr_t base);
		for (int i = 0; i < n; i++)
		begin
			if (ret_src_q[first+i] != src)
				report_mismatch("ret source", 32'(ret_src_q[first+i]), 32'(src));
			if (ret_data_q[first+i] != read_word(base, i))
				report_mismatch("ret_data", ret_data_q[first+i], read_word(base, i));
			if (ret_last_q[first+i] != (i == n - 1))
				report_mismatch("ret_last", 32'(ret_last_q[first+i]), 32'(i == n - 1));
		end
	endtask

	task automatic do_read(logic from_dcache, addr_t addr, logic uncached);
		int n;
		int target;
		size_t size;
		n = uncached ? 1 : line_beats;
		size = uncached ? size_t'($urandom_range(2, 0)) : 3'd2;
		ret_data_q.delete();
		ret_last_q.delete();
		ret_src_q.delete();
		target = lasts_seen + 1;
		step();
		if (from_dcache)
		begin
			dcache_rd_req = 1'b1;
			dcache_rd_addr = addr;
			dcache_rd_size = size;
			dcache_rd_uncached = uncached;
		end
		else
		begin
			icache_rd_req = 1'b1;
			icache_rd_addr = addr;
			icache_rd_size = size;
		end
		@(negedge clk);
		while (!(from_dcache ? dcache_rd_rdy : icache_rd_rdy))
			@(negedge clk);
		step();
		icache_rd_req = 1'b0;
		dcache_rd_req = 1'b0;
		while (lasts_seen < target)
			@(posedge clk);
		if (ret_data_q.size() != n)
			report_mismatch("read beat count", 32'(ret_data_q.size()), 32'(n));
		else
			check_beats(0, n, from_dcache, addr);
		if (u_slave.last_arlen != len_t'(n - 1))
			report_mismatch("arlen at slave", 32'(u_slave.last_arlen), 32'(n - 1));
		if (u_slave.last_arsize != size)
			report_mismatch("arsize at slave", 32'(u_slave.last_arsize), 32'(size));
		if (u_slave.last_arburst != (uncached ? burst_fixed : burst_incr))
			report_mismatch("arburst at slave", 32'(u_slave.last_arburst), 32'(!uncached));
	endtask

	task automatic do_arb(addr_t ia, addr_t da);
		int target;
		ret_data_q.delete();
		ret_last_q.delete();
		ret_src_q.delete();
		target = lasts_seen + 2;
		step();
		icache_rd_req = 1'b1;
		icache_rd_addr = ia;
		dcache_rd_req = 1'b1;
		dcache_rd_addr = da;
		dcache_rd_uncached = 1'b0;
		@(negedge clk);
		if (icache_rd_rdy != 1'b1)
			report_mismatch("icache_rd_rdy on tie", 32'(icache_rd_rdy), 32'd1);
		if (dcache_rd_rdy != 1'b0)
			report_mismatch("dcache_rd_rdy on tie", 32'(dcache_rd_rdy), 32'd0);
		step();
		icache_rd_req = 1'b0;   // dcache keeps asking
		@(negedge clk);
		while (!dcache_rd_rdy)
			@(negedge clk);
		step();
		dcache_rd_req = 1'b0;
		while (lasts_seen < target)
			@(posedge clk);
		if (ret_data_q.size() != 2 * line_beats)
			report_mismatch("arbitrated beat count", 32'(ret_data_q.size()), 32'(2 * line_beats));
		else
		begin
			check_beats(0, line_beats, 1'b0, ia);
			check_beats(line_beats, line_beats, 1'b1, da);
		end
	endtask

	task automatic do_write(addr_t addr, logic uncached);
		logic [line_beats*data_w-1:0] line;
		data_t word;
		strb_t strb;
		size_t size;
		logic [31:0] r;
		data_t exp;
		int n;
		int base;
		int k;
		for (int i = 0; i < line_beats; i++)
			line[i*data_w +: data_w] = $urandom;
		word = $urandom;
		r = $urandom;
		strb = uncached ? (r[3:0] | 4'h1) : 4'hf;
		size = uncached ? size_t'($urandom_range(2, 0)) : 3'd2;
		n = uncached ? 1 : line_beats;
		base = u_slave.log_cnt;
		step();
		dcache_wr_req = 1'b1;
		dcache_wr_addr = addr;
		dcache_wr_size = size;
		dcache_wr_strb = strb;
		dcache_wr_uncached = uncached;
		dcache_wr_line = line;
		dcache_wr_word = word;
		@(negedge clk);
		while (!dcache_wr_rdy)
			@(negedge clk);
		step();
		dcache_wr_req = 1'b0;
		@(negedge clk);
		while (!dcache_wr_rdy)   // back in idle once B is taken
			@(negedge clk);
		if (u_slave.log_cnt - base != n)
			report_mismatch("write beat count", 32'(u_slave.log_cnt - base), 32'(n));
		else
			for (int i = 0; i < n; i++)
			begin
				k = base + i;
				exp = uncached ? word : line[i*data_w +: data_w];
				if (u_slave.log_data[k] != exp)
					report_mismatch("wdata", u_slave.log_data[k], exp);
				if (u_slave.log_last[k] != (i == n - 1))
					report_mismatch("wlast", 32'(u_slave.log_last[k]), 32'(i == n - 1));
				if (u_slave.log_strb[k] != strb)
					report_mismatch("wstrb", 32'(u_slave.log_strb[k]), 32'(strb));
				if (u_slave.log_addr[k] != addr)
					report_mismatch("awaddr", u_slave.log_addr[k], addr);
				if (u_slave.log_len[k] != len_t'(n - 1))
					report_mismatch("awlen", 32'(u_slave.log_len[k]), 32'(n - 1));
				if (u_slave.log_size[k] != size)
					report_mismatch("awsize", 32'(u_slave.log_size[k]), 32'(size));
				if (u_slave.log_burst[k] != (uncached ? burst_fixed : burst_incr))
					report_mismatch("awburst", 32'(u_slave.log_burst[k]), 32'(!uncached));
			end
	endtask

	task automatic end_test(string name, int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - errs_before);
		end
	endtask

	initial
	begin
		int e0;
		logic [31:0] r1;
		logic [31:0] r2;
		void'($urandom(32'hdfec_ae15));
		rst = 1'b0;
		icache_rd_req = 1'b0;
		icache_rd_addr = '0;
		icache_rd_size = 3'd2;
		dcache_rd_req = 1'b0;
		dcache_rd_addr = '0;
		dcache_rd_size = 3'd2;
		dcache_rd_uncached = 1'b0;
		dcache_wr_req = 1'b0;
		dcache_wr_addr = '0;
		dcache_wr_size = 3'd2;
		dcache_wr_strb = '0;
		dcache_wr_uncached = 1'b0;
		dcache_wr_line = '0;
		dcache_wr_word = '0;
		repeat (4) @(posedge clk);
		#5 rst = 1'b1;

		e0 = errors;
		@(negedge clk);
		if (arvalid || awvalid || wvalid)
			report_mismatch("valids after reset", {29'd0, arvalid, awvalid, wvalid}, 32'd0);
		if (!(icache_rd_rdy && dcache_rd_rdy && dcache_wr_rdy))
			report_mismatch("rdy after reset",
				{29'd0, icache_rd_rdy, dcache_rd_rdy, dcache_wr_rdy}, 32'd7);
		end_test("reset state", e0);

		e0 = errors;
		for (int t = 0; t < 30; t++)
		begin
			r1 = $urandom;
			do_read(t[0], {r1[31:6], 6'd0}, 1'b0);   // alternate icache and dcache
		end
		end_test("cached reads", e0);

		e0 = errors;
		for (int t = 0; t < 30; t++)
		begin
			r1 = $urandom;
			do_read(1'b1, {r1[31:2], 2'd0}, 1'b1);
		end
		end_test("uncached reads", e0);

		e0 = errors;
		for (int t = 0; t < 10; t++)
		begin
			r1 = $urandom;
			r2 = $urandom;
			do_arb({r1[31:6], 6'd0}, {r2[31:6], 6'd0});
		end
		end_test("arbitration", e0);

		e0 = errors;
		for (int t = 0; t < 30; t++)
		begin
			r1 = $urandom;
			do_write({r1[31:6], 6'd0}, 1'b0);
		end
		end_test("line writes", e0);

		e0 = errors;
		for (int t = 0; t < 30; t++)
		begin
			r1 = $urandom;
			do_write({r1[31:2], 2'd0}, 1'b1);
		end
		end_test("uncached writes", e0);

		e0 = errors;
		for (int t = 0; t < 10; t++)
		begin
			r1 = $urandom;
			r2 = $urandom;
			fork
				do_read(r1[0], {r1[31:6], 6'd0}, 1'b0);
				do_write({r2[31:2], 2'd0}, r2[0]);
			join
		end
		end_test("writes during reads", e0);

		$display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
common/axi_bridge_pkg.sv
axi_bridge/read_channel.sv
axi_bridge/write_buffer.sv
axi_bridge/write_channel.sv
axi_bridge/axi_bridge.sv
tb/tb_axi_slave.sv
tb/axi_bridge_assert.sv
tb/tb_axi_bridge.sv

/* Makefile */
TOP = tb_axi_bridge

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
